/* read_path_settings.svh */
//--------------------------------------------------------------------------
// global sizing macros for the DDR2 AFI read valid path: latency count
// width, memory word width, capture FIFO depth and calibration limits
//--------------------------------------------------------------------------
`ifndef READ_PATH_SETTINGS_SVH
`define READ_PATH_SETTINGS_SVH

// width of the latency count, giving 2**LAT_WIDTH shifter taps
`define LAT_WIDTH 4

// width of one word returned by the memory
`define DATA_WIDTH 32

// number of words the capture FIFO can hold
`define FIFO_DEPTH 8

// extra cycles added on top of the measured round trip
`define CAL_MARGIN 1

// cycle limit while waiting for the test word to come back
`define CAL_TIMEOUT 20

`endif

/* read_path_pkg.sv */
//--------------------------------------------------------------------------
// shared types of the read valid path: latency and tap vectors, memory
// word, memory return struct and calibrator state encoding
//--------------------------------------------------------------------------
`include "read_path_settings.svh"

package read_path_pkg;

	// one latency count, selects a single shifter tap
	typedef logic [`LAT_WIDTH-1:0] lat_count_t;

	// one bit per tap, used for both the shifter history and the decoded mask
	typedef logic [(2**`LAT_WIDTH)-1:0] lat_taps_t;

	// a single memory word
	typedef logic [`DATA_WIDTH-1:0] rdata_t;

	// one returned word together with its strobe
	typedef struct packed {
		logic   valid;
		rdata_t data;
	} mem_return_t;

	// calibration sequence, from the test read to the final verdict
	typedef enum logic [2:0] {
		st_idle,
		st_issue,
		st_wait_return,
		st_settle,
		st_done,
		st_fail
	} cal_state_t;

endpackage

/* read_latency_shifter.sv */
//--------------------------------------------------------------------------
// read_latency_shifter: shift register holding a one-hot history of
// read data enable pulses, one tap per cycle of age
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module read_latency_shifter
	import read_path_pkg::*;
(
	input  logic      pll_afi_clk,
	input  logic      reset_n,
	input  logic      rdata_en,
	output lat_taps_t latency_shifter
);

	// number of taps, one per possible latency count
	localparam int TAPS = $bits(lat_taps_t);

	// each enable pulse enters at bit 0 and moves up one tap per cycle,
	// so bit k is set k+1 cycles after the enable was sampled
	// several pulses can travel at once when reads are issued closely
	// the oldest history simply falls off the top tap
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			// no reads outstanding after reset
			latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <= {latency_shifter[TAPS-2:0], rdata_en};
		end
	end

endmodule

/* read_valid_selector.sv */
//--------------------------------------------------------------------------
// read_valid_selector: decodes the latency count to a registered tap mask
// and raises read_enable and read_valid when the selected tap fires
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module read_valid_selector
	import read_path_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       reset_n,
	input  lat_taps_t  latency_shifter,
	input  lat_count_t latency_counter,
	output logic       read_enable,
	output logic       read_valid
);

	// one-hot decode of the current count
	lat_taps_t selector;

	// registered copy of the decode, lags the count by one cycle
	lat_taps_t selector_reg;

	// taps that are both selected and carrying a pulse
	lat_taps_t valid_select;

	// plain binary to one-hot decode of the latency count
	always_comb
	begin
		selector = '0;
		selector[latency_counter] = 1'b1;
	end

	// the mask is registered to keep the decoder out of the output path
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			selector_reg <= '0;
		end
		else
		begin
			selector_reg <= selector;
		end
	end

	// only one mask bit is set, so at most one tap can match
	assign valid_select = selector_reg & latency_shifter;

	// both strobes rise one cycle after the selected tap is set
	// read_enable pops the capture FIFO while read_valid flags the same word
	// to the controller, so the two are always equal
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			read_enable <= 1'b0;
			read_valid  <= 1'b0;
		end
		else
		begin
			read_enable <= |valid_select;
			read_valid  <= |valid_select;
		end
	end

endmodule

/* read_capture_fifo.sv */
//--------------------------------------------------------------------------
// read_capture_fifo: show-ahead circular buffer for returned memory words,
// with flush and a sticky underflow flag
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "read_path_settings.svh"

module read_capture_fifo
	import read_path_pkg::*;
(
	input  logic        pll_afi_clk,
	input  logic        reset_n,
	input  mem_return_t mem_return,
	input  logic        pop,
	input  logic        flush,
	input  logic        check_underflow,
	output rdata_t      head,
	output logic        empty,
	output logic        rd_underflow
);

	localparam int PTR_W = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

	// word storage, written only on an accepted push
	rdata_t mem [`FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic full;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(`FIFO_DEPTH));

	// a pop on an empty buffer is ignored here, the flag below records it
	assign do_pop = pop && !empty;

	// a word that arrives while the buffer is full is dropped,
	// unless the head leaves in the same cycle
	assign do_push = mem_return.valid && (!full || do_pop);

	// show-ahead, the oldest word is always presented
	assign head = mem[rd_ptr];

	always_ff @(posedge pll_afi_clk)
	begin
		if (do_push)
		begin
			mem[wr_ptr] <= mem_return.data;
		end
	end

	// pointers wrap at the configured depth, which need not be a power of two
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (flush)
		begin
			// flush wins over any push or pop in the same cycle
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			unique case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// early pops during calibration are expected, so checking starts only
	// once the latency is known; the flag then stays set until reset
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			rd_underflow <= 1'b0;
		end
		else if (pop && empty && check_underflow)
		begin
			rd_underflow <= 1'b1;
		end
	end

endmodule

/* read_latency_calibrator.sv */
//--------------------------------------------------------------------------
// read_latency_calibrator: FSM that issues one test read after reset,
// measures the round trip and sets the read latency count
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "read_path_settings.svh"

module read_latency_calibrator
	import read_path_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       reset_n,
	input  logic       fifo_empty,
	output logic       cal_rdata_en,
	output lat_count_t latency_counter,
	output logic       fifo_flush,
	output logic       cal_done,
	output logic       cal_fail
);

	// largest count the selector can use
	localparam int LAT_MAX = (2**`LAT_WIDTH) - 1;

	// wide enough for the timeout plus margin and for LAT_MAX
	localparam int CNT_W = $clog2(`CAL_TIMEOUT + `CAL_MARGIN + LAT_MAX + 2);

	cal_state_t state;

	// start delay in idle, round-trip cycles while waiting
	logic [CNT_W-1:0] cnt;

	// measured round trip plus margin, and the same less the fixed pipeline
	logic [CNT_W-1:0] lat_sum;
	logic [CNT_W-1:0] lat_trim;
	logic             lat_too_big;

	// the fixed two cycles of shifter and selector pipeline come off the
	// measured count, and a short round trip clamps at a count of zero
	always_comb
	begin
		lat_sum     = cnt + CNT_W'(`CAL_MARGIN);
		lat_trim    = (lat_sum < CNT_W'(2)) ? '0 : lat_sum - CNT_W'(2);
		lat_too_big = (lat_trim > CNT_W'(LAT_MAX));
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state           <= st_idle;
			cnt             <= '0;
			cal_rdata_en    <= 1'b0;
			latency_counter <= '0;
			fifo_flush      <= 1'b0;
			cal_done        <= 1'b0;
			cal_fail        <= 1'b0;
		end
		else
		begin
			unique case (state)
				st_idle:
				begin
					// two cycles out of reset, then the test read goes out
					if (cnt == CNT_W'(1))
					begin
						state        <= st_issue;
						cal_rdata_en <= 1'b1;
						cnt          <= '0;
					end
					else
					begin
						cnt <= cnt + 1'b1;
					end
				end
				st_issue:
				begin
					// single cycle pulse, the count starts on the next cycle
					cal_rdata_en <= 1'b0;
					state        <= st_wait_return;
				end
				st_wait_return:
				begin
					if (!fifo_empty)
					begin
						// the test word is in, cnt now equals the round trip
						if (lat_too_big)
						begin
							cal_fail <= 1'b1;
							state    <= st_fail;
						end
						else
						begin
							latency_counter <= lat_count_t'(lat_trim);
							fifo_flush      <= 1'b1;
							state           <= st_settle;
						end
					end
					else if (cnt == CNT_W'(`CAL_TIMEOUT))
					begin
						// nothing came back in time
						cal_fail <= 1'b1;
						state    <= st_fail;
					end
					else
					begin
						cnt <= cnt + 1'b1;
					end
				end
				st_settle:
				begin
					// test word discarded, report success a cycle later
					fifo_flush <= 1'b0;
					cal_done   <= 1'b1;
					state      <= st_done;
				end
				st_done:
				begin
					// latency held until the next reset
					state <= st_done;
				end
				st_fail:
				begin
					state <= st_fail;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

/* read_path_top.sv */
//--------------------------------------------------------------------------
// read_path_top: AFI read valid path with latency shifter, valid selector,
// capture FIFO and round-trip calibrator
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module read_path_top
	import read_path_pkg::*;
(
	input  logic        pll_afi_clk,
	input  logic        reset_n,
	input  logic        afi_rdata_en,
	input  mem_return_t mem_return,
	output rdata_t      afi_rdata,
	output logic        afi_rdata_valid,
	output logic        cal_done,
	output logic        cal_fail,
	output lat_count_t  read_latency,
	output logic        rd_underflow
);

	// controller and calibration enables share the shifter
	logic       rdata_en;
	logic       cal_rdata_en;
	lat_taps_t  latency_shifter;
	lat_count_t latency_counter;
	logic       read_enable;
	logic       fifo_flush;
	logic       fifo_empty;

	// the controller stays quiet until cal_done, so the OR never merges two
	// real requests
	assign rdata_en = afi_rdata_en | cal_rdata_en;

	assign read_latency = latency_counter;

	read_latency_shifter i_shifter (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.rdata_en        (rdata_en),
		.latency_shifter (latency_shifter)
	);

	read_valid_selector i_selector (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.latency_shifter (latency_shifter),
		.latency_counter (latency_counter),
		.read_enable     (read_enable),
		.read_valid      (afi_rdata_valid)
	);

	// underflow is only meaningful once the latency has been calibrated
	read_capture_fifo i_fifo (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.mem_return      (mem_return),
		.pop             (read_enable),
		.flush           (fifo_flush),
		.check_underflow (cal_done),
		.head            (afi_rdata),
		.empty           (fifo_empty),
		.rd_underflow    (rd_underflow)
	);

	read_latency_calibrator i_calibrator (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.fifo_empty      (fifo_empty),
		.cal_rdata_en    (cal_rdata_en),
		.latency_counter (latency_counter),
		.fifo_flush      (fifo_flush),
		.cal_done        (cal_done),
		.cal_fail        (cal_fail)
	);

endmodule

/* read_path_checker.sv */
//--------------------------------------------------------------------------
// concurrent assertions on the read valid path top level and their bind
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module read_path_checker
	import read_path_pkg::*;
(
	input logic       pll_afi_clk,
	input logic       reset_n,
	input logic       cal_done,
	input logic       cal_fail,
	input lat_count_t read_latency,
	input logic       afi_rdata_valid,
	input logic       fifo_empty,
	input logic       rd_underflow
);

	// failure counts, one per assertion
	int exclusive_fails = 0;
	int latency_fails = 0;
	int underflow_fails = 0;

	// calibration ends in exactly one verdict
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n) !(cal_done && cal_fail))
	else
	begin
		$error("cal_done and cal_fail are high together");
		exclusive_fails++;
	end

	// the calibrated latency is held until the next reset
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		cal_done |=> $stable(read_latency))
	else
	begin
		$error("read_latency changed after cal_done");
		latency_fails++;
	end

	// a valid on an empty FIFO after calibration must always be flagged
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		cal_done && afi_rdata_valid && fifo_empty |=> rd_underflow)
	else
	begin
		$error("afi_rdata_valid on an empty FIFO was not flagged");
		underflow_fails++;
	end

endmodule

bind read_path_top read_path_checker i_checker (
	.pll_afi_clk     (pll_afi_clk),
	.reset_n         (reset_n),
	.cal_done        (cal_done),
	.cal_fail        (cal_fail),
	.read_latency    (read_latency),
	.afi_rdata_valid (afi_rdata_valid),
	.fifo_empty      (fifo_empty),
	.rd_underflow    (rd_underflow)
);

/* read_path_tb.sv */
//--------------------------------------------------------------------------
// directed testbench for the read valid path: clock and reset, memory
// return model, valid monitor, calibration, read, flush and underflow tests
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "read_path_settings.svh"

module read_path_tb
	import read_path_pkg::*;
();

	logic        pll_afi_clk;
	logic        reset_n;
	logic        afi_rdata_en;
	mem_return_t mem_return = '0;
	rdata_t      afi_rdata;
	logic        afi_rdata_valid;
	logic        cal_done;
	logic        cal_fail;
	lat_count_t  read_latency;
	logic        rd_underflow;

	// round trip of the memory model in cycles
	int rt_delay = 9;
	int seed = 32'hf633_7a65;
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int overflows = 0;
	int next_expect = 1;
	int suppress_cyc = -10;

	// model state that only the negedge process below writes
	int     due_q[$];
	int     word_idx = 0;
	rdata_t cal_word = '0;
	bit     cal_word_seen = 1'b0;

	// cycle and data of every valid seen after cal_done
	int     valid_cyc_q[$];
	rdata_t valid_data_q[$];

	// cycle at which each controller read was driven
	int issue_q[$];

	read_path_top i_dut (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.afi_rdata_en    (afi_rdata_en),
		.mem_return      (mem_return),
		.afi_rdata       (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid),
		.cal_done        (cal_done),
		.cal_fail        (cal_fail),
		.read_latency    (read_latency),
		.rd_underflow    (rd_underflow)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #2 pll_afi_clk = ~pll_afi_clk;
	end

	// cycle number that stays stable around every falling edge
	always @(posedge pll_afi_clk)
	begin
		cyc <= cyc + 1;
	end

	// returned words count up from a fixed base and word 0 is the test read
	function automatic rdata_t word_pattern(input int n);
		return rdata_t'(32'h5a5a_0000 + n);
	endfunction

	// the calibrated count is the round trip plus the margin less the two
	// pipeline stages of shifter and selector, and it never goes below zero
	function automatic int expected_latency(input int round_trip);
		int lat;
		lat = round_trip + `CAL_MARGIN - 2;
		if (lat < 0)
			lat = 0;
		return lat;
	endfunction

	// the memory model and the valid monitor both work on the falling edge
	// a request is seen on shifter tap 0 one cycle after it was driven, and
	// its word is pushed into the FIFO rt_delay cycles after the request edge
	always @(negedge pll_afi_clk)
	begin
		if (!reset_n)
		begin
			due_q.delete();
			mem_return = '0;
			word_idx = 0;
			cal_word = '0;
			cal_word_seen = 1'b0;
		end
		else
		begin
			mem_return = '0;
			if (due_q.size() > 0 && due_q[0] == cyc)
			begin
				void'(due_q.pop_front());
				mem_return.valid = 1'b1;
				mem_return.data = word_pattern(word_idx);
				if (word_idx == 0)
					cal_word = mem_return.data;
				word_idx++;
				assert (!i_dut.i_fifo.full)
				else
				begin
					overflows++;
					$display("t=%0t capture FIFO full, a returned word is dropped", $time);
				end
			end
			if (i_dut.latency_shifter[0] && cyc != suppress_cyc + 1)
				due_q.push_back(cyc + rt_delay - 1);
			if (cal_done && afi_rdata_valid)
			begin
				valid_cyc_q.push_back(cyc);
				valid_data_q.push_back(afi_rdata);
				if (afi_rdata == cal_word)
					cal_word_seen = 1'b1;
			end
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got == exp)
		else
		begin
			errors++;
			$display("[FAIL] t=%0t %s: got 'h%0h expected 'h%0h", $time, name, got, exp);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1)
		else
		begin
			errors++;
			$display("t=%0t %s", $time, what);
		end
	endtask

	// reset for 8 cycles with a new model round trip
	task automatic apply_reset(input int delay);
		@(negedge pll_afi_clk);
		reset_n = 1'b0;
		rt_delay = delay;
		next_expect = 1;
		repeat (8) @(negedge pll_afi_clk);
		reset_n = 1'b1;
	endtask

	// one controller request followed by gap idle cycles
	task automatic send_pulse(input int gap);
		afi_rdata_en = 1'b1;
		issue_q.push_back(cyc);
		@(negedge pll_afi_clk);
		afi_rdata_en = 1'b0;
		repeat (gap) @(negedge pll_afi_clk);
	endtask

	// each valid must come latency+2 cycles after its request and in request order
	task automatic collect_reads(input int first, input int n);
		int lat;
		int waited;
		int i;
		lat = expected_latency(rt_delay);
		waited = 0;
		while (valid_cyc_q.size() - first < n && waited < lat + 4 * n + 16)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		expect_true(valid_cyc_q.size() - first >= n, "timed out waiting for afi_rdata_valid");
		// further cycles to catch a valid that should not be there
		repeat (lat + 8) @(negedge pll_afi_clk);
		check_value("valid count", 64'(valid_cyc_q.size() - first), 64'(n));
		for (i = 0; i < n && first + i < valid_cyc_q.size(); i++)
		begin
			check_value("afi_rdata_valid cycle", 64'(valid_cyc_q[first + i]),
				64'(issue_q[i] + lat + 2));
			check_value("afi_rdata", 64'(valid_data_q[first + i]),
				64'(word_pattern(next_expect)));
			next_expect++;
		end
	endtask

	task automatic await_calibration();
		int waited;
		int exp_lat;
		waited = 0;
		while (!cal_done && !cal_fail && waited < `CAL_TIMEOUT + 10)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		expect_true(cal_done, "cal_done did not rise within the calibration time");
		check_value("cal_fail", 64'(cal_fail), 64'(0));
		exp_lat = expected_latency(rt_delay);
		check_value("read_latency", 64'(read_latency), 64'(exp_lat));
		repeat (4) @(negedge pll_afi_clk);
	endtask

	task automatic single_read();
		int first;
		first = valid_cyc_q.size();
		issue_q.delete();
		send_pulse(0);
		collect_reads(first, 1);
	endtask

	task automatic burst_reads();
		int first;
		int gap;
		first = valid_cyc_q.size();
		issue_q.delete();
		repeat (5) send_pulse(0);
		collect_reads(first, 5);
		// same again with random idle gaps of 0 to 3 cycles
		first = valid_cyc_q.size();
		issue_q.delete();
		repeat (5)
		begin
			gap = $unsigned($random(seed)) % 4;
			send_pulse(gap);
		end
		collect_reads(first, 5);
	endtask

	task automatic confirm_flush();
		check_value("test word", 64'(cal_word), 64'(word_pattern(0)));
		expect_true(!cal_word_seen, "the calibration test word reached afi_rdata as valid");
		check_value("fifo_empty", 64'(i_dut.fifo_empty), 64'(1));
	endtask

	// a request whose word never comes back pops an empty FIFO
	task automatic force_underflow();
		int waited;
		check_value("rd_underflow", 64'(rd_underflow), 64'(0));
		suppress_cyc = cyc;
		send_pulse(0);
		waited = 0;
		while (!rd_underflow && waited < expected_latency(rt_delay) + 12)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		expect_true(rd_underflow, "rd_underflow not set by a read with no returned word");
	endtask

	task automatic calibration_failure();
		int waited;
		apply_reset(25);
		waited = 0;
		while (!cal_fail && !cal_done && waited < `CAL_TIMEOUT + 10)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		expect_true(cal_fail, "cal_fail did not rise for a round trip beyond the timeout");
		check_value("cal_done", 64'(cal_done), 64'(0));
	endtask

	initial
	begin
		int total;
		reset_n = 1'b0;
		afi_rdata_en = 1'b0;
		apply_reset(9);
		await_calibration();
		single_read();
		burst_reads();
		confirm_flush();
		force_underflow();
		calibration_failure();
		total = errors + overflows + i_dut.i_checker.exclusive_fails
			+ i_dut.i_checker.latency_fails + i_dut.i_checker.underflow_fails;
		$display("checks %0d, errors %0d, overflows %0d, all failures %0d",
			checks, errors, overflows, total);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* read_path_top.f */
+incdir+.
read_path_pkg.sv
read_latency_shifter.sv
read_valid_selector.sv
read_capture_fifo.sv
read_latency_calibrator.sv
read_path_top.sv
read_path_checker.sv
read_path_tb.sv

/* Makefile */
# Verilator build and run of the read valid path testbench

VERILATOR ?= verilator
TOP       ?= read_path_tb
FILELIST  ?= read_path_top.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the run passes only when the pass message appears as a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
